// ==== hw/mem_pkg.sv ====
// Memory unit package with cache and memory geometry, width types and access codes
package mem_pkg;

    localparam int XLEN          = 32;
    localparam int NUM_WAYS      = 2;
    localparam int SET_BITS      = 9;                               // 512 sets per way
    localparam int MEM_ADDR_BITS = 14;                              // 16 KiB of byte address
    localparam int TAG_BITS      = MEM_ADDR_BITS - SET_BITS - 2;
    localparam int NUM_SETS      = 2 ** SET_BITS;
    localparam int MEM_WORDS     = 2 ** (MEM_ADDR_BITS - 2);

    typedef logic [XLEN-1:0]     word_t;
    typedef logic [SET_BITS-1:0] set_idx_t;                         // addr[10:2]
    typedef logic [TAG_BITS-1:0] tag_t;                             // addr[13:11]
    typedef logic [NUM_WAYS-1:0] way_mask_t;
    typedef logic [2:0]          access_t;                          // funct3

    localparam access_t ACC_LB  = 3'b000;
    localparam access_t ACC_LH  = 3'b001;
    localparam access_t ACC_LW  = 3'b010;
    localparam access_t ACC_LBU = 3'b100;
    localparam access_t ACC_LHU = 3'b101;

    // Stores share funct3 with the signed loads
    localparam access_t ACC_SB  = ACC_LB;
    localparam access_t ACC_SH  = ACC_LH;
    localparam access_t ACC_SW  = ACC_LW;

    // Byte lanes written by a store, one bit per byte of the word
    function automatic logic [3:0] store_lanes(access_t acc, logic [1:0] offset);
        case (acc)
            ACC_SB:  store_lanes = 4'b0001 << offset;
            ACC_SH:  store_lanes = offset[1] ? 4'b1100 : 4'b0011;
            ACC_SW:  store_lanes = 4'b1111;
            default: store_lanes = 4'b0000;                         // Not a store code
        endcase
    endfunction

    // Store data replicated so each lane sees its own byte
    function automatic word_t store_data(access_t acc, word_t wdata);
        case (acc)
            ACC_SB:  store_data = {4{wdata[7:0]}};
            ACC_SH:  store_data = {2{wdata[15:0]}};
            default: store_data = wdata;
        endcase
    endfunction

endpackage

// ==== hw/way_if.sv ====
// Way interface between the cache controller, one cache way and the load aligner
`timescale 1ns/1ps

interface way_if import mem_pkg::*; ();

    set_idx_t index;        // Set selected by the access
    tag_t     tag;          // Tag compared against the stored one
    logic     fill;         // Load miss refill into this way
    logic     store;        // Store update of a hitting line
    word_t    wdata;        // Merged store word or memory word
    logic     hit;
    word_t    rdata;        // Word held at index

    modport ctrl (
        output index,
        output tag,
        output fill,
        output store,
        output wdata,
        input  hit
    );

    modport way (
        input  index,
        input  tag,
        input  fill,
        input  store,
        input  wdata,
        output hit,
        output rdata
    );

    modport drain (input hit, input rdata);

endinterface

// ==== hw/cache_way.sv ====
// Cache way with tag, valid and data arrays, combinational lookup and edge updates
`timescale 1ns/1ps

module cache_way import mem_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    way_if.way   port
);

    logic [NUM_SETS-1:0] valid_q;                   // Cleared by reset
    tag_t                tag_q  [NUM_SETS];
    word_t               data_q [NUM_SETS];

    logic                cur_valid;
    tag_t                cur_tag;

    // Lookup
    assign cur_valid  = valid_q[port.index];
    assign cur_tag    = tag_q[port.index];
    assign port.hit   = cur_valid && (cur_tag == port.tag);
    assign port.rdata = data_q[port.index];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (port.fill) begin
            valid_q[port.index] <= 1'b1;
        end
    end

    // Tag and data arrays
    always_ff @(posedge clk) begin
        if (port.fill) begin
            tag_q[port.index] <= port.tag;
        end
        if (port.fill || port.store) begin
            data_q[port.index] <= port.wdata;       // Refill word or merged store word
        end
    end

    fill_store_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(port.fill && port.store)
    ) else $error("cache_way: fill and store raised together");

endmodule

// ==== hw/cache_ctrl.sv ====
// Cache controller that splits the address, merges store bytes, keeps LRU and drives the ways
`timescale 1ns/1ps

module cache_ctrl import mem_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    re,
    input  logic    we,
    input  word_t   addr,
    input  word_t   wdata,
    input  access_t acc,
    input  word_t   mem_word,                       // Current memory word at addr
    way_if.ctrl     ways [NUM_WAYS]
);

    set_idx_t            index;
    tag_t                tag;
    way_mask_t           hit_vec;
    logic                any_hit;
    logic [3:0]          lanes;
    word_t               lane_wdata;
    word_t               merged;
    word_t               way_wdata;
    logic [NUM_SETS-1:0] lru_q;                     // Names the next victim way per set
    logic                victim;
    logic                used_way;

    assign index = addr[SET_BITS+1:2];
    assign tag   = addr[MEM_ADDR_BITS-1:SET_BITS+2];

    // Store merge uses the same lane rule as the memory
    assign lanes      = store_lanes(acc, addr[1:0]);
    assign lane_wdata = store_data(acc, wdata);

    always_comb begin
        merged = mem_word;
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) begin
                merged[8*b +: 8] = lane_wdata[8*b +: 8];
            end
        end
    end

    assign way_wdata = we ? merged : mem_word;      // Fills take the memory word
    assign any_hit   = |hit_vec;
    assign victim    = lru_q[index];

    // Two ways, so the hit bit of way 1 is the index of the hitting way
    assign used_way  = any_hit ? hit_vec[1] : victim;

    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
        assign hit_vec[g]     = ways[g].hit;
        assign ways[g].index  = index;
        assign ways[g].tag    = tag;
        assign ways[g].wdata  = way_wdata;
        assign ways[g].store  = we && hit_vec[g];   // Write-through, no allocate
        assign ways[g].fill   = re && !any_hit && (victim == 1'(g));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_q <= '0;
        end else if (re) begin
            lru_q[index] <= ~used_way;              // Point away from the way just used
        end
    end

    rw_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(re && we)
    ) else $error("cache_ctrl: load and store in the same cycle");

endmodule

// ==== hw/load_align.sv ====
// Load aligner that picks the hit way or memory word and extends the addressed byte or half
`timescale 1ns/1ps

module load_align import mem_pkg::*; (
    input  logic    re,
    input  word_t   addr,
    input  access_t acc,
    input  word_t   mem_word,
    way_if.drain    ways [NUM_WAYS],
    output word_t   rdata,
    output logic    hit
);

    way_mask_t  hit_vec;
    word_t      way_words [NUM_WAYS];
    word_t      src;
    logic [1:0] byte_off;
    logic [7:0] sel_byte;
    logic [15:0] sel_half;

    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
        assign hit_vec[g]   = ways[g].hit;
        assign way_words[g] = ways[g].rdata;
    end

    assign hit      = re && (|hit_vec);
    assign byte_off = addr[1:0];

    always_comb begin
        src = mem_word;                             // Miss falls back to memory
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (hit_vec[i]) begin
                src = way_words[i];
            end
        end
    end

    assign sel_byte = src[8*byte_off +: 8];
    assign sel_half = byte_off[1] ? src[31:16] : src[15:0];

    always_comb begin
        case (acc)
            ACC_LB:  rdata = {{24{sel_byte[7]}}, sel_byte};
            ACC_LH:  rdata = {{16{sel_half[15]}}, sel_half};
            ACC_LW:  rdata = src;
            ACC_LBU: rdata = {24'b0, sel_byte};
            ACC_LHU: rdata = {16'b0, sel_half};
            default: rdata = '0;                    // Unsupported funct3
        endcase
    end

    // Fills only happen on a miss, so one set never holds a line twice
    always_comb begin
        if (re) begin
            onehot_hit: assert final ($onehot0(hit_vec))
                else $error("load_align: more than one way hit");
        end
    end

endmodule

// ==== hw/data_mem.sv ====
// Main memory of 4096 words with asynchronous read and byte-lane stores
`timescale 1ns/1ps

module data_mem import mem_pkg::*; (
    input  logic    clk,
    input  logic    we,
    input  word_t   addr,
    input  word_t   wdata,
    input  access_t acc,
    output word_t   rdata
);

    word_t                    mem [MEM_WORDS];    // Contents survive reset
    logic [MEM_ADDR_BITS-3:0] word_idx;
    logic [3:0]               lanes;
    word_t                    lane_wdata;

    assign word_idx   = addr[MEM_ADDR_BITS-1:2];
    assign lanes      = store_lanes(acc, addr[1:0]);
    assign lane_wdata = store_data(acc, wdata);

    assign rdata = mem[word_idx];                   // Combinational read

    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (lanes[b]) begin
                    mem[word_idx][8*b +: 8] <= lane_wdata[8*b +: 8];
                end
            end
        end
    end

    sh_aligned: assert property (
        @(posedge clk)
        (we && acc == ACC_SH) |-> !addr[0]
    ) else $error("data_mem: misaligned halfword store");

    sw_aligned: assert property (
        @(posedge clk)
        (we && acc == ACC_SW) |-> (addr[1:0] == 2'b00)
    ) else $error("data_mem: misaligned word store");

endmodule

// ==== hw/memory_unit.sv ====
// Memory unit top with a two-way set-associative data cache over main memory
`timescale 1ns/1ps

module memory_unit import mem_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    re,
    input  logic    we,
    input  word_t   addr,
    input  word_t   wdata,
    input  access_t acc,
    output word_t   rdata,
    output logic    hit
);

    word_t mem_word;                                // Memory word at addr, read every cycle

    way_if ways [NUM_WAYS] ();

    data_mem main_mem_inst (
        .clk   (clk),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .acc   (acc),
        .rdata (mem_word)
    );

    cache_ctrl cache_ctrl_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .re       (re),
        .we       (we),
        .addr     (addr),
        .wdata    (wdata),
        .acc      (acc),
        .mem_word (mem_word),
        .ways     (ways)
    );

    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
        cache_way way_inst (
            .clk   (clk),
            .rst_n (rst_n),
            .port  (ways[g])
        );
    end

    load_align load_align_inst (
        .re       (re),
        .addr     (addr),
        .acc      (acc),
        .mem_word (mem_word),
        .ways     (ways),
        .rdata    (rdata),
        .hit      (hit)
    );

endmodule

// ==== sim/tb_memory_unit.sv ====
// Directed testbench for the memory unit with a byte-level reference model of memory and cache
`timescale 1ns/1ps

module tb_memory_unit import mem_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int MAX_CYCLES = 2000;               // Watchdog limit for the whole run

    logic    clk;
    logic    rst_n;
    logic    re;
    logic    we;
    word_t   addr;
    word_t   wdata;
    access_t acc;
    word_t   rdata;
    logic    hit;

    // Reference model of memory bytes plus per-set valid, tag and LRU state
    logic [7:0] model_mem   [MEM_WORDS][4];
    logic       model_valid [NUM_WAYS][NUM_SETS];
    tag_t       model_tag   [NUM_WAYS][NUM_SETS];
    logic       model_lru   [NUM_SETS];

    integer seed;
    int     test_errors;
    int     pass_count;
    int     fail_count;

    memory_unit dut0 (
        .clk   (clk),
        .rst_n (rst_n),
        .re    (re),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .acc   (acc),
        .rdata (rdata),
        .hit   (hit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Stops a run whose clock or test flow got stuck
    initial begin
        for (int i = 0; i < MAX_CYCLES; i++) begin
            #(CLK_PERIOD);
        end
        $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    function automatic word_t random_word();
        random_word = $random(seed);
    endfunction

    function automatic int find_way(word_t a);
        set_idx_t s;
        tag_t     t;
        s = a[10:2];
        t = a[13:11];
        find_way = -1;                              // Miss
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (model_valid[w][s] && model_tag[w][s] == t) begin
                find_way = w;
            end
        end
    endfunction

    // Expected load result from the model bytes
    function automatic word_t expect_load(word_t a, access_t c);
        logic [7:0]  b;
        logic [15:0] h;
        word_t       w;
        w = {model_mem[a[13:2]][3], model_mem[a[13:2]][2],
             model_mem[a[13:2]][1], model_mem[a[13:2]][0]};
        b = model_mem[a[13:2]][a[1:0]];
        h = a[1] ? w[31:16] : w[15:0];
        case (c)
            ACC_LB:  expect_load = {{24{b[7]}}, b};
            ACC_LH:  expect_load = {{16{h[15]}}, h};
            ACC_LW:  expect_load = w;
            ACC_LBU: expect_load = {24'b0, b};
            ACC_LHU: expect_load = {16'b0, h};
            default: expect_load = '0;
        endcase
    endfunction

    task automatic model_store(input word_t a, input access_t c, input word_t d);
        case (c)
            ACC_SB: model_mem[a[13:2]][a[1:0]] = d[7:0];
            ACC_SH: begin
                model_mem[a[13:2]][{a[1], 1'b0}] = d[7:0];
                model_mem[a[13:2]][{a[1], 1'b1}] = d[15:8];
            end
            ACC_SW: begin
                model_mem[a[13:2]][0] = d[7:0];
                model_mem[a[13:2]][1] = d[15:8];
                model_mem[a[13:2]][2] = d[23:16];
                model_mem[a[13:2]][3] = d[31:24];
            end
            default: ;                              // Other codes write nothing
        endcase
    endtask

    // Load fills the LRU victim on a miss, then points LRU away from the used way
    task automatic model_load(input word_t a);
        set_idx_t s;
        int       w;
        s = a[10:2];
        w = find_way(a);
        if (w < 0) begin
            w = model_lru[s] ? 1 : 0;
            model_valid[w][s] = 1'b1;
            model_tag[w][s]   = a[13:11];
        end
        model_lru[s] = (w == 0);
    endtask

    task automatic model_clear_cache();
        for (int s = 0; s < NUM_SETS; s++) begin
            model_lru[s] = 1'b0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                model_valid[w][s] = 1'b0;
            end
        end
    endtask

    task automatic check_word(input string name, input word_t exp_v, input word_t act_v);
        if (act_v !== exp_v) begin
            $display("FAILED at %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, exp_v, act_v);
            test_errors++;
        end
    endtask

    task automatic check_hit(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, exp_v, act_v);
            test_errors++;
        end
    endtask

    task automatic wait_edges(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
        end
    endtask

    // Drives one access and samples outputs 2 ns before the edge that commits it
    task automatic access_cycle(input logic is_load, input word_t a, input access_t c,
                                input word_t d);
        wait_edges(1);
        #2;
        re    = is_load;
        we    = ~is_load;
        addr  = a;
        acc   = c;
        wdata = d;
        #(CLK_PERIOD - 4);
    endtask

    task automatic go_idle();
        wait_edges(1);
        #2;
        re = 1'b0;
        we = 1'b0;
    endtask

    task automatic do_store(input word_t a, input access_t c, input word_t d);
        access_cycle(1'b0, a, c, d);
        check_hit("hit", 1'b0, hit);
        model_store(a, c, d);
    endtask

    task automatic do_load(input word_t a, input access_t c);
        word_t exp_data;
        logic  exp_hit;
        exp_data = expect_load(a, c);
        exp_hit  = (find_way(a) >= 0);
        access_cycle(1'b1, a, c, '0);
        check_word("rdata", exp_data, rdata);
        check_hit("hit", exp_hit, hit);
        model_load(a);
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("Test %s passed", name);
            pass_count++;
        end else begin
            $display("Test %s failed with %0d mismatches", name, test_errors);
            fail_count++;
        end
        test_errors = 0;
    endtask

    task automatic test_word_store_load();
        do_store(32'h0000_0100, ACC_SW, random_word());
        do_load(32'h0000_0100, ACC_LW);             // No allocate, so a miss
        do_load(32'h0000_0100, ACC_LW);             // Filled by the first load
        finish_test("word_store_load");
    endtask

    task automatic test_partial_stores();
        word_t a;
        do_store(32'h0000_0200, ACC_SW, random_word());
        do_load(32'h0000_0200, ACC_LW);
        for (int k = 0; k < 4; k++) begin
            do_store(32'h0000_0200 + word_t'(k), ACC_SB, random_word());
            do_load(32'h0000_0200, ACC_LW);         // Cached line follows the store
        end
        for (int k = 0; k < 2; k++) begin
            do_store(32'h0000_0200 + word_t'(2 * k), ACC_SH, random_word());
            do_load(32'h0000_0200, ACC_LW);
        end
        // Fresh word each step keeps the line out of the cache at the partial store
        for (int k = 0; k < 6; k++) begin
            a = 32'h0000_0300 + word_t'(4 * k);
            do_store(a, ACC_SW, random_word());
            if (k < 4) begin
                do_store(a + word_t'(k), ACC_SB, random_word());
            end else begin
                do_store(a + word_t'(2 * (k - 4)), ACC_SH, random_word());
            end
            do_load(a, ACC_LW);
        end
        finish_test("partial_stores");
    endtask

    task automatic test_load_extension();
        word_t a;
        word_t w;
        for (int n = 0; n < 4; n++) begin
            a = 32'h0000_0400 + word_t'(4 * n);
            w = random_word();
            w = n[0] ? (w & 32'h7f7f_7f7f) : (w | 32'h8080_8080);  // Both sign cases
            do_store(a, ACC_SW, w);
            for (int b = 0; b < 4; b++) begin
                do_load(a + word_t'(b), ACC_LB);
                do_load(a + word_t'(b), ACC_LBU);
            end
            for (int h = 0; h < 2; h++) begin
                do_load(a + word_t'(2 * h), ACC_LH);
                do_load(a + word_t'(2 * h), ACC_LHU);
            end
            do_load(a, ACC_LW);
        end
        finish_test("load_extension");
    endtask

    task automatic test_lru_replacement();
        word_t a_addr;
        word_t b_addr;
        word_t c_addr;
        a_addr = {18'b0, 3'd1, 9'h1f0, 2'b00};      // Same set, tags 1, 2 and 3
        b_addr = {18'b0, 3'd2, 9'h1f0, 2'b00};
        c_addr = {18'b0, 3'd3, 9'h1f0, 2'b00};
        do_store(a_addr, ACC_SW, random_word());
        do_store(b_addr, ACC_SW, random_word());
        do_store(c_addr, ACC_SW, random_word());
        do_load(a_addr, ACC_LW);
        do_load(b_addr, ACC_LW);
        do_load(a_addr, ACC_LW);
        do_load(c_addr, ACC_LW);                    // Evicts B
        do_load(a_addr, ACC_LW);
        do_load(b_addr, ACC_LW);
        finish_test("lru_replacement");
    endtask

    task automatic test_reset();
        go_idle();
        rst_n = 1'b0;
        model_clear_cache();
        wait_edges(4);
        #2;
        rst_n = 1'b1;
        do_load(32'h0000_0100, ACC_LW);             // Memory kept, valid bits gone
        do_load(32'h0000_0100, ACC_LW);
        finish_test("reset");
    endtask

    task automatic test_unsupported_codes();
        access_t bad_codes [5];
        bad_codes = '{3'b011, 3'b100, 3'b101, 3'b110, 3'b111};
        do_store(32'h0000_0a00, ACC_SW, random_word());
        do_store(32'h0000_0b00, ACC_SW, random_word());
        do_load(32'h0000_0a00, 3'b011);
        do_load(32'h0000_0a00, 3'b110);
        do_load(32'h0000_0a00, 3'b111);
        for (int i = 0; i < 5; i++) begin
            do_store(32'h0000_0a00, bad_codes[i], random_word());  // Cached line
            do_store(32'h0000_0b00, bad_codes[i], random_word());  // Uncached line
        end
        do_load(32'h0000_0a00, ACC_LW);
        do_load(32'h0000_0b00, ACC_LW);             // Miss reads the memory word
        finish_test("unsupported_codes");
    endtask

    initial begin
        rst_n       = 1'b0;
        re          = 1'b0;
        we          = 1'b0;
        addr        = '0;
        wdata       = '0;
        acc         = ACC_LW;
        seed        = 5;
        test_errors = 0;
        pass_count  = 0;
        fail_count  = 0;
        model_clear_cache();
        wait_edges(4);
        #2;
        rst_n = 1'b1;

        test_word_store_load();
        test_partial_stores();
        test_load_extension();
        test_lru_replacement();
        test_reset();
        test_unsupported_codes();
        go_idle();

        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
hw/mem_pkg.sv
hw/way_if.sv
hw/cache_way.sv
hw/cache_ctrl.sv
hw/load_align.sv
hw/data_mem.sv
hw/memory_unit.sv
sim/tb_memory_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_memory_unit \
    -f sim.f --Mdir obj_dir -o tb_memory_unit > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_memory_unit > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
